// File: verilog/demodPkg.sv
// widths and fixed-point constants of the FM monitor path
// register reset values, DAC source and register address encodings
`default_nettype none

package demodPkg;

    // datapath widths
    localparam int sampleW  = 18;
    localparam int productW = 2 * sampleW;
    // 1.0 is 2^17
    localparam int fracBits = 17;
    localparam int coefW    = 16;

    // Wishbone
    localparam int busW  = 32;
    localparam int addrW = 2;

    // false-lock detector constants
    localparam logic [sampleW-1:0] halfScale      = 18'h10000;
    // 0x8000 << 2 is 1.0
    localparam logic [coefW-1:0]   alphaReset     = 16'h8000;
    localparam logic [coefW-1:0]   thresholdReset = 16'h4000;

    // diagnostic DAC sources, unused codes select dacI
    typedef enum logic [2:0] {
        dacI          = 3'd0,
        dacQ          = 3'd1,
        dacFreq       = 3'd2,
        dacAvgFreq    = 3'd3,
        dacAvgAbsFreq = 3'd4
    } dacSourceE;

    // word addresses of the register bank
    typedef enum logic [addrW-1:0] {
        regDacSelect = 2'd0,
        regAlpha     = 2'd1,
        regThreshold = 2'd2,
        regStatus    = 2'd3
    } regAddrE;

endpackage

`default_nettype wire

// File: verilog/demodRegs.sv
// Wishbone classic register bank
// DAC select, averaging alpha, lock threshold and read-only status
`timescale 1ns/1ps
`default_nettype none

module demodRegs (
    input  wire                          clk,
    input  wire                          arstN,
    input  wire                          wbCyc,
    input  wire                          wbStb,
    input  wire                          wbWe,
    input  wire  [demodPkg::addrW-1:0]   wbAdr,
    input  wire  [demodPkg::busW-1:0]    wbDatI,
    input  wire  [3:0]                   wbSel,
    input  wire                          highFreqOffset,
    output logic                         wbAck,
    output logic [demodPkg::busW-1:0]    wbDatO,
    output demodPkg::dacSourceE          dacSelect,
    output logic [demodPkg::coefW-1:0]   falseLockAlpha,
    output logic [demodPkg::coefW-1:0]   falseLockThreshold
);

    demodPkg::regAddrE regAddr;
    logic              accessEn;
    logic              writeEn;

    assign regAddr  = demodPkg::regAddrE'(wbAdr);
    // first edge of a cycle that is not yet acked
    assign accessEn = wbCyc && wbStb && !wbAck;
    assign writeEn  = accessEn && wbWe;

    // byte-lane merge for the 16-bit fields
    function automatic logic [demodPkg::coefW-1:0] mergeBytes(
        input logic [demodPkg::coefW-1:0] oldVal,
        input logic [demodPkg::busW-1:0]  newVal,
        input logic [3:0]                 sel
    );
        logic [demodPkg::coefW-1:0] result;
        result = oldVal;
        if (sel[0]) begin
            result[7:0] = newVal[7:0];
        end
        if (sel[1]) begin
            result[15:8] = newVal[15:8];
        end
        return result;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= accessEn;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dacSelect          <= demodPkg::dacI;
            falseLockAlpha     <= demodPkg::alphaReset;
            falseLockThreshold <= demodPkg::thresholdReset;
        end else if (writeEn) begin
            case (regAddr)
                demodPkg::regDacSelect: begin
                    if (wbSel[0]) begin
                        dacSelect <= demodPkg::dacSourceE'(wbDatI[2:0]);
                    end
                end
                demodPkg::regAlpha: begin
                    falseLockAlpha <= mergeBytes(falseLockAlpha, wbDatI, wbSel);
                end
                demodPkg::regThreshold: begin
                    falseLockThreshold <= mergeBytes(falseLockThreshold, wbDatI, wbSel);
                end
                // status is read only
                default: ;
            endcase
        end
    end

    // read mux, address is held by the master until ack
    always_comb begin
        wbDatO = '0;
        case (regAddr)
            demodPkg::regDacSelect: wbDatO[2:0] = dacSelect;
            demodPkg::regAlpha:     wbDatO[demodPkg::coefW-1:0] = falseLockAlpha;
            demodPkg::regThreshold: wbDatO[demodPkg::coefW-1:0] = falseLockThreshold;
            default:                wbDatO[0] = highFreqOffset;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/fmDiscriminator.sv
// cross-product FM discriminator over consecutive I/Q samples
`timescale 1ns/1ps
`default_nettype none

module fmDiscriminator (
    input  wire                                 clk,
    input  wire                                 arstN,
    input  wire                                 sampleEn,
    input  wire  signed [demodPkg::sampleW-1:0] iIn,
    input  wire  signed [demodPkg::sampleW-1:0] qIn,
    output logic signed [demodPkg::sampleW-1:0] fmVideo,
    output logic                                fmValid
);

    logic signed [demodPkg::sampleW-1:0]  iPrev;
    logic signed [demodPkg::sampleW-1:0]  qPrev;
    logic signed [demodPkg::productW-1:0] crossIq;
    logic signed [demodPkg::productW-1:0] crossQi;
    logic signed [demodPkg::productW-1:0] crossDiff;

    // im{conj(prev) * cur} ~ phase step between strobes
    assign crossIq   = iPrev * qIn;
    assign crossQi   = qPrev * iIn;
    assign crossDiff = crossIq - crossQi;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            iPrev   <= '0;
            qPrev   <= '0;
            fmVideo <= '0;
            fmValid <= 1'b0;
        end else begin
            fmValid <= sampleEn;
            if (sampleEn) begin
                iPrev   <= iIn;
                qPrev   <= qIn;
                // drop the duplicated sign bit and rescale to 1.17
                fmVideo <= crossDiff[demodPkg::fracBits+demodPkg::sampleW-1:
                                     demodPkg::fracBits];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/freqAverager.sv
// exponential averages of frequency and absolute frequency
// false-lock decision driving highFreqOffset
`timescale 1ns/1ps
`default_nettype none

module freqAverager (
    input  wire                                 clk,
    input  wire                                 arstN,
    input  wire  signed [demodPkg::sampleW-1:0] fmVideo,
    input  wire                                 fmValid,
    input  wire         [demodPkg::coefW-1:0]   falseLockAlpha,
    input  wire         [demodPkg::coefW-1:0]   falseLockThreshold,
    input  wire                                 carrierLock,
    output logic signed [demodPkg::sampleW-1:0] avgFreq,
    output logic signed [demodPkg::sampleW-1:0] avgAbsFreq,
    output logic                                avgValid,
    output logic                                highFreqOffset
);

    // weights carry one extra bit so 1.0 stays positive
    logic signed [demodPkg::sampleW:0]   alphaW;
    logic signed [demodPkg::sampleW:0]   betaW;
    logic        [demodPkg::sampleW-1:0] absFmVideo;
    logic        [demodPkg::sampleW-1:0] absAvgFreq;
    logic signed [demodPkg::sampleW-1:0] nextAvgFreq;
    logic signed [demodPkg::sampleW-1:0] nextAvgAbsFreq;

    // avg' = (x * alpha + avg * (1 - alpha)) >> fracBits
    function automatic logic signed [demodPkg::sampleW-1:0] expStep(
        input logic signed [demodPkg::sampleW:0] sample,
        input logic signed [demodPkg::sampleW:0] avg,
        input logic signed [demodPkg::sampleW:0] wNew,
        input logic signed [demodPkg::sampleW:0] wOld
    );
        logic signed [demodPkg::productW+1:0] acc;
        acc = sample * wNew + avg * wOld;
        return acc[demodPkg::fracBits+demodPkg::sampleW-1:demodPkg::fracBits];
    endfunction

    assign alphaW = $signed({1'b0, falseLockAlpha, 2'b00});
    assign betaW  = $signed({2'b01, {demodPkg::fracBits{1'b0}}}) - alphaW;

    assign absFmVideo = fmVideo[demodPkg::sampleW-1] ? -fmVideo : fmVideo;
    assign absAvgFreq = avgFreq[demodPkg::sampleW-1] ? -avgFreq : avgFreq;

    assign nextAvgFreq = expStep({fmVideo[demodPkg::sampleW-1], fmVideo},
                                 {avgFreq[demodPkg::sampleW-1], avgFreq}, alphaW, betaW);
    // abs path is unsigned, zero-extend
    assign nextAvgAbsFreq = expStep({1'b0, absFmVideo}, {1'b0, avgAbsFreq}, alphaW, betaW);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            avgFreq        <= '0;
            avgAbsFreq     <= '0;
            avgValid       <= 1'b0;
            highFreqOffset <= 1'b0;
        end else begin
            avgValid <= fmValid;
            if (fmValid) begin
                avgFreq    <= nextAvgFreq;
                avgAbsFreq <= nextAvgAbsFreq;
            end
            // decide one cycle after the averages move
            if (avgValid) begin
                if ($unsigned(avgAbsFreq) > demodPkg::halfScale) begin
                    highFreqOffset <= 1'b1;
                end else if (absAvgFreq > {2'b00, falseLockThreshold}) begin
                    highFreqOffset <= !carrierLock;
                end else begin
                    highFreqOffset <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/dacMux.sv
// diagnostic DAC source selection, registered with its own sync strobe
`timescale 1ns/1ps
`default_nettype none

module dacMux (
    input  wire                                 clk,
    input  wire                                 arstN,
    input  demodPkg::dacSourceE                 dacSelect,
    input  wire                                 sampleEn,
    input  wire  signed [demodPkg::sampleW-1:0] iIn,
    input  wire  signed [demodPkg::sampleW-1:0] qIn,
    input  wire  signed [demodPkg::sampleW-1:0] fmVideo,
    input  wire                                 fmValid,
    input  wire  signed [demodPkg::sampleW-1:0] avgFreq,
    input  wire  signed [demodPkg::sampleW-1:0] avgAbsFreq,
    input  wire                                 avgValid,
    output logic signed [demodPkg::sampleW-1:0] dacData,
    output logic                                dacSync
);

    logic signed [demodPkg::sampleW-1:0] iHold;
    logic signed [demodPkg::sampleW-1:0] qHold;
    logic signed [demodPkg::sampleW-1:0] iSrc;
    logic signed [demodPkg::sampleW-1:0] qSrc;

    // newest strobed sample, held between strobes
    assign iSrc = sampleEn ? iIn : iHold;
    assign qSrc = sampleEn ? qIn : qHold;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            iHold   <= '0;
            qHold   <= '0;
            dacData <= '0;
            dacSync <= 1'b0;
        end else begin
            iHold <= iSrc;
            qHold <= qSrc;
            case (dacSelect)
                demodPkg::dacQ: begin
                    dacData <= qSrc;
                    dacSync <= sampleEn;
                end
                demodPkg::dacFreq: begin
                    dacData <= fmVideo;
                    dacSync <= fmValid;
                end
                demodPkg::dacAvgFreq: begin
                    dacData <= avgFreq;
                    dacSync <= avgValid;
                end
                demodPkg::dacAvgAbsFreq: begin
                    dacData <= avgAbsFreq;
                    dacSync <= avgValid;
                end
                // dacI and the unused codes
                default: begin
                    dacData <= iSrc;
                    dacSync <= sampleEn;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/demodTop.sv
// FM monitor path top level
// register bank, discriminator, false-lock averager and DAC mux
`timescale 1ns/1ps
`default_nettype none

module demodTop (
    input  wire                                clk,
    input  wire                                arstN,
    input  wire                                wbCyc,
    input  wire                                wbStb,
    input  wire                                wbWe,
    input  wire        [demodPkg::addrW-1:0]   wbAdr,
    input  wire        [demodPkg::busW-1:0]    wbDatI,
    input  wire        [3:0]                   wbSel,
    input  wire                                sampleEn,
    input  wire signed [demodPkg::sampleW-1:0] iIn,
    input  wire signed [demodPkg::sampleW-1:0] qIn,
    input  wire                                carrierLock,
    output wire                                wbAck,
    output wire        [demodPkg::busW-1:0]    wbDatO,
    output wire signed [demodPkg::sampleW-1:0] fmVideo,
    output wire                                fmValid,
    output wire                                highFreqOffset,
    output wire signed [demodPkg::sampleW-1:0] dacData,
    output wire                                dacSync
);

    demodPkg::dacSourceE               dacSelect;
    wire [demodPkg::coefW-1:0]         falseLockAlpha;
    wire [demodPkg::coefW-1:0]         falseLockThreshold;
    wire signed [demodPkg::sampleW-1:0] avgFreq;
    wire signed [demodPkg::sampleW-1:0] avgAbsFreq;
    wire                               avgValid;

    demodRegs regs (
        .clk(clk), .arstN(arstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatI(wbDatI), .wbSel(wbSel),
        .highFreqOffset(highFreqOffset),
        .wbAck(wbAck), .wbDatO(wbDatO),
        .dacSelect(dacSelect),
        .falseLockAlpha(falseLockAlpha),
        .falseLockThreshold(falseLockThreshold)
    );

    fmDiscriminator disc (
        .clk(clk), .arstN(arstN),
        .sampleEn(sampleEn), .iIn(iIn), .qIn(qIn),
        .fmVideo(fmVideo), .fmValid(fmValid)
    );

    freqAverager averager (
        .clk(clk), .arstN(arstN),
        .fmVideo(fmVideo), .fmValid(fmValid),
        .falseLockAlpha(falseLockAlpha),
        .falseLockThreshold(falseLockThreshold),
        .carrierLock(carrierLock),
        .avgFreq(avgFreq), .avgAbsFreq(avgAbsFreq),
        .avgValid(avgValid), .highFreqOffset(highFreqOffset)
    );

    dacMux dac (
        .clk(clk), .arstN(arstN),
        .dacSelect(dacSelect),
        .sampleEn(sampleEn), .iIn(iIn), .qIn(qIn),
        .fmVideo(fmVideo), .fmValid(fmValid),
        .avgFreq(avgFreq), .avgAbsFreq(avgAbsFreq), .avgValid(avgValid),
        .dacData(dacData), .dacSync(dacSync)
    );

endmodule

`default_nettype wire

// File: verification/demod_asserts.sv
// concurrent timing checks on the bus ack, the discriminator strobe and the DAC sync
`timescale 1ns/1ps
`default_nettype none

module demodAsserts (
    input wire clk,
    input wire arstN,
    input wire wbAck,
    input wire sampleEn,
    input wire fmValid,
    input wire avgValid,
    input wire dacSync
);

    // count of failed checks
    int failures = 0;

    // ack lasts one clock
    ackPulse: assert property (@(posedge clk) disable iff (!arstN) wbAck |=> !wbAck) else begin
        failures = failures + 1;
        $error("wbAck stayed high for a second cycle");
    end

    fmAfterSample: assert property (@(posedge clk) disable iff (!arstN)
        sampleEn |=> fmValid) else begin
        failures = failures + 1;
        $error("fmValid missing one cycle after sampleEn");
    end

    fmOnlyAfterSample: assert property (@(posedge clk) disable iff (!arstN)
        !sampleEn |=> !fmValid) else begin
        failures = failures + 1;
        $error("fmValid without a sampleEn one cycle before");
    end

    // no strobe from any source, no sync
    syncIdle: assert property (@(posedge clk) disable iff (!arstN)
        (!sampleEn && !fmValid && !avgValid) |=> !dacSync) else begin
        failures = failures + 1;
        $error("dacSync high after a cycle with no source strobe");
    end

endmodule

bind demodTop demodAsserts timingChecks (
    .clk(clk),
    .arstN(arstN),
    .wbAck(wbAck),
    .sampleEn(sampleEn),
    .fmValid(fmValid),
    .avgValid(avgValid),
    .dacSync(dacSync)
);

`default_nettype wire

// File: verification/tbDemod.sv
// testbench for the FM monitor path
// Wishbone master, I/Q stimulus, reference model, immediate checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tbDemod;

    localparam int randSamples = 40;
    localparam int maxGap      = 3;
    localparam int rotSamples  = 24;
    // random bursts, seven rotation runs, about thirty bus accesses
    localparam int stimCycles  = 6 * randSamples * (maxGap + 1)
                               + 7 * (2 * rotSamples + 4) + 30 * 4;
    localparam int timeoutNs   = stimCycles * 20 + 2000;
    localparam longint unity   = longint'(1) << demodPkg::fracBits;

    logic clk = 1'b0;
    logic arstN, wbCyc, wbStb, wbWe, sampleEn, carrierLock;
    logic [demodPkg::addrW-1:0] wbAdr;
    logic [demodPkg::busW-1:0]  wbDatI;
    logic [3:0]                 wbSel;
    logic signed [demodPkg::sampleW-1:0] iIn, qIn;
    wire wbAck, fmValid, highFreqOffset, dacSync;
    wire [demodPkg::busW-1:0] wbDatO;
    wire signed [demodPkg::sampleW-1:0] fmVideo, dacData;

    // reference model state starts at zero like the DUT after reset
    logic signed [17:0] mIPrev = '0, mQPrev = '0, mFm = '0, mAvg = '0;
    logic signed [17:0] mIHold = '0, mQHold = '0;
    logic [17:0] mAbs = '0, mDac = '0;
    logic mFmValid = 1'b0, mAvgValid = 1'b0, mHfo = 1'b0, mSync = 1'b0;
    // register contents as written by the master
    logic [2:0]  shSel;
    logic [15:0] shAlpha, shThr;
    longint alphaQ, acc, absFm, absAvg;
    int phase = 0;
    logic [31:0] codes [6] = '{32'd0, 32'd1, 32'd2, 32'd3, 32'd4, 32'd7};

    demodTop dut (.*);

    always #10 clk = ~clk;

    task automatic mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    // first failure of a bound timing assertion ends the run
    always @(dut.timingChecks.failures) begin
        if (dut.timingChecks.failures != 0) begin
            $display("a bound timing assertion failed at %0t", $time);
            $display("Something failed");
            $fatal(1, "timing assertion");
        end
    end

    // model steps at each edge from the values before the edge
    always @(posedge clk) begin
        if (arstN) begin
            if (mAvgValid) begin
                absAvg = (mAvg < 0) ? -longint'(mAvg) : longint'(mAvg);
                if (mAbs > demodPkg::halfScale) begin
                    mHfo = 1'b1;
                end else begin
                    mHfo = (absAvg > longint'(shThr)) ? !carrierLock : 1'b0;
                end
            end
            if (sampleEn) begin
                mIHold = iIn;
                mQHold = qIn;
            end
            mSync = sampleEn;
            case (shSel)
                demodPkg::dacQ:          mDac = mQHold;
                demodPkg::dacFreq:       mDac = mFm;
                demodPkg::dacAvgFreq:    mDac = mAvg;
                demodPkg::dacAvgAbsFreq: mDac = mAbs;
                default:                 mDac = mIHold;
            endcase
            if (shSel == demodPkg::dacFreq) begin
                mSync = mFmValid;
            end else if (shSel == demodPkg::dacAvgFreq || shSel == demodPkg::dacAvgAbsFreq) begin
                mSync = mAvgValid;
            end
            // exponential averages with alpha scaled by 4
            if (mFmValid) begin
                alphaQ = longint'(shAlpha) * 4;
                absFm = (mFm < 0) ? -longint'(mFm) : longint'(mFm);
                acc = longint'(mFm) * alphaQ + longint'(mAvg) * (unity - alphaQ);
                mAvg = 18'(acc >>> demodPkg::fracBits);
                acc = absFm * alphaQ + longint'(mAbs) * (unity - alphaQ);
                mAbs = 18'(acc >>> demodPkg::fracBits);
            end
            mAvgValid = mFmValid;
            if (sampleEn) begin
                acc = longint'(mIPrev) * longint'(qIn) - longint'(mQPrev) * longint'(iIn);
                mFm = 18'(acc >>> demodPkg::fracBits);
                mIPrev = iIn;
                mQPrev = qIn;
            end
            mFmValid = sampleEn;
        end
    end

    always @(negedge clk) begin
        if (arstN) begin
            assert (fmValid == mFmValid) else mismatch("fmValid differs from model");
            assert (fmVideo == mFm)
                else mismatch($sformatf("fmVideo %0d, expected %0d", fmVideo, mFm));
            assert (dacSync == mSync) else mismatch("dacSync differs from model");
            assert (dacData == mDac)
                else mismatch($sformatf("dacData %05h, expected %05h", dacData, mDac));
            assert (highFreqOffset == mHfo) else mismatch("highFreqOffset differs from model");
        end
    end

    // one Wishbone classic access with read data checked against the model
    task automatic busAccess(input logic we, input logic [1:0] adr,
                             input logic [31:0] dat, input logic [3:0] sel);
        logic [15:0] mask;
        logic [31:0] expData;
        @(posedge clk);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= we;
        wbAdr  <= adr;
        wbDatI <= dat;
        wbSel  <= sel;
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        mask = {{8{sel[1]}}, {8{sel[0]}}};
        case (adr)
            2'd0:    expData = {29'd0, shSel};
            2'd1:    expData = {16'd0, shAlpha};
            2'd2:    expData = {16'd0, shThr};
            default: expData = {31'd0, mHfo};
        endcase
        if (!we) begin
            assert (wbDatO == expData)
                else mismatch($sformatf("read %0d gave %08h, expected %08h", adr, wbDatO, expData));
        end else if (adr == 2'd0 && sel[0]) begin
            shSel = dat[2:0];
        end else if (adr == 2'd1) begin
            shAlpha = (shAlpha & ~mask) | (dat[15:0] & mask);
        end else if (adr == 2'd2) begin
            shThr = (shThr & ~mask) | (dat[15:0] & mask);
        end
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
    endtask

    task automatic sendSample(input logic signed [17:0] i, input logic signed [17:0] q,
                              input int gap);
        sampleEn <= 1'b1;
        iIn      <= i;
        qIn      <= q;
        @(posedge clk);
        sampleEn <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    // quarter-turn steps give a constant fm of amp^2 >> 17
    task automatic rotate(input int amp, input int dir, input int count);
        logic signed [17:0] a;
        a = 18'(amp);
        repeat (count) begin
            case (phase)
                0:       sendSample(a, 18'sd0, 1);
                1:       sendSample(18'sd0, a, 1);
                2:       sendSample(-a, 18'sd0, 1);
                default: sendSample(18'sd0, -a, 1);
            endcase
            phase = (phase + dir + 4) % 4;
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic checkFlag(input logic expected, input string what);
        @(negedge clk);
        assert (highFreqOffset == expected)
            else mismatch($sformatf("highFreqOffset is %0b %s", highFreqOffset, what));
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'ha406));
        arstN       = 1'b0;
        wbCyc       = 1'b0;
        wbStb       = 1'b0;
        wbWe        = 1'b0;
        wbAdr       = '0;
        wbDatI      = '0;
        wbSel       = '0;
        sampleEn    = 1'b0;
        iIn         = '0;
        qIn         = '0;
        carrierLock = 1'b0;
        shSel       = 3'd0;
        shAlpha     = demodPkg::alphaReset;
        shThr       = demodPkg::thresholdReset;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;

        // reset values, byte lanes, read-only status
        for (int a = 0; a < 4; a++) begin
            busAccess(1'b0, 2'(a), 32'd0, 4'hF);
        end
        busAccess(1'b1, 2'd1, 32'h0000_1234, 4'hF);
        busAccess(1'b1, 2'd1, 32'hFFFF_ABCD, 4'h2);
        busAccess(1'b1, 2'd2, 32'h0000_5678, 4'h1);
        busAccess(1'b1, 2'd0, 32'h0000_0007, 4'h2);
        busAccess(1'b1, 2'd3, 32'hFFFF_FFFF, 4'hF);
        for (int a = 0; a < 4; a++) begin
            busAccess(1'b0, 2'(a), 32'd0, 4'hF);
        end
        busAccess(1'b1, 2'd1, 32'h8000, 4'h3);
        busAccess(1'b1, 2'd2, 32'h4000, 4'h3);

        // random samples through every DAC source and one unused code
        foreach (codes[k]) begin
            busAccess(1'b1, 2'd0, codes[k], 4'h1);
            repeat (randSamples) begin
                sendSample(18'($urandom), 18'($urandom), int'($urandom % (maxGap + 1)));
            end
        end

        // alpha 0.25 on both averages
        busAccess(1'b1, 2'd1, 32'h2000, 4'h3);
        busAccess(1'b1, 2'd0, 32'(demodPkg::dacAvgFreq), 4'h1);
        rotate(65536, 1, rotSamples);
        busAccess(1'b1, 2'd0, 32'(demodPkg::dacAvgAbsFreq), 4'h1);
        rotate(65536, -1, rotSamples);

        // false lock at alpha 1.0 and an fm of 0x8000
        busAccess(1'b1, 2'd1, 32'h8000, 4'h3);
        carrierLock <= 1'b0;
        rotate(65536, 1, rotSamples);
        checkFlag(1'b1, "above threshold without carrier lock");
        busAccess(1'b0, 2'd3, 32'd0, 4'hF);
        carrierLock <= 1'b1;
        rotate(65536, 1, rotSamples);
        checkFlag(1'b0, "above threshold with carrier lock");
        carrierLock <= 1'b0;
        busAccess(1'b1, 2'd2, 32'hC000, 4'h3);
        rotate(65536, 1, rotSamples);
        checkFlag(1'b0, "below a raised threshold");
        rotate(100000, 1, rotSamples);
        checkFlag(1'b1, "past half scale without carrier lock");
        carrierLock <= 1'b1;
        rotate(100000, 1, rotSamples);
        checkFlag(1'b1, "past half scale with carrier lock");
        busAccess(1'b0, 2'd3, 32'd0, 4'hF);

        repeat (4) @(posedge clk);
        if (dut.timingChecks.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("%0d timing assertions failed", dut.timingChecks.failures);
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("watchdog: run did not finish within %0d ns", timeoutNs);
        $display("Something failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/demodPkg.sv
verilog/demodRegs.sv
verilog/fmDiscriminator.sv
verilog/freqAverager.sv
verilog/dacMux.sv
verilog/demodTop.sv
verification/demod_asserts.sv
verification/tbDemod.sv

// File: runSim.sh
#!/bin/sh
# build and run the FM monitor path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tbDemod -f filelist.f -o simDemod \
    && ./obj_dir/simDemod | tee sim.log \
    && grep -q "Everything OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
